//--- common/chiplet_config.svh
`ifndef CHIPLET_CONFIG_SVH
`define CHIPLET_CONFIG_SVH

// ====================
// Endpoint sizing
// ====================

// Message slots, one trigger bit each.
`define CHIP_NUM_MSGS 4

// Words held by the message FIFO.
`define CHIP_FIFO_DEPTH 16

// ====================
// Field widths
// ====================

// Packet length in words, header included.
`define CHIP_PKT_LEN_W 8

`define CHIP_NODE_ID_W 4 // Sender id.

`endif

//--- common/chiplet_pkg.sv
`include "chiplet_config.svh"

package chiplet_pkg;

    // ====================
    // Plain vectors
    // ====================

    typedef logic [31:0] word_t;
    typedef logic [`CHIP_PKT_LEN_W-1:0] pkt_len_t;
    typedef logic [1:0] pkt_id_t; // Message slot.
    typedef logic [`CHIP_NODE_ID_W-1:0] node_id_t;

    // ====================
    // Packet format
    // ====================

    typedef enum logic [3:0] {
        FMT_LONG_READ  = 4'd0,
        FMT_LONG_WRITE = 4'd1,
        FMT_SHORT      = 4'd2,
        FMT_SWITCH_CFG = 4'd3
    } format_e;

    typedef struct packed {
        format_e      format;   // Bits 31:28.
        pkt_len_t     length;   // All words, header included.
        logic [19:0]  reserved;
    } long_hdr_t;

    typedef struct packed {
        logic     vc;
        pkt_id_t  id;
        node_id_t req; // Sending node.
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t metadata;
        word_t      payload;
    } flit_t;

    // Transmit controller states.
    typedef enum logic [1:0] {
        IDLE,
        START_SEND_PKT,
        SEND_PKT,
        CRC
    } tx_state_e;

endpackage

//--- logic/msg_fifo.sv
`timescale 1ns/1ps
`include "chiplet_config.svh"

module msg_fifo #(
    parameter int DEPTH = `CHIP_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               wr_req,
    input  chiplet_pkg::word_t wr_data,
    input  logic               pop,
    output logic               wr_ack,
    output chiplet_pkg::word_t head_word,
    output logic               not_empty
);
    import chiplet_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam ptr_t LAST_PTR = ptr_t'(DEPTH - 1);
    localparam cnt_t FULL_CNT = cnt_t'(DEPTH);

    word_t mem [DEPTH];
    ptr_t  rd_ptr, wr_ptr;
    cnt_t  count;
    logic  full, push;

    assign full      = (count == FULL_CNT);
    assign not_empty = (count != '0);
    assign head_word = mem[rd_ptr]; // Show-ahead.

    // New request seen, previous handshake finished.
    assign push = wr_req && !wr_ack && !full;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ack <= 1'b0;
        end else if (push) begin
            wr_ack <= 1'b1;
        end else if (wr_ack && !wr_req) begin
            wr_ack <= 1'b0; // Phase 4.
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!n_rst)
        pop |-> not_empty);

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(wr_ack) |-> $past(wr_req));

endmodule

//--- logic/crc32_gen.sv
`timescale 1ns/1ps

module crc32_gen (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               clear,
    input  logic               update,
    input  chiplet_pkg::word_t data,
    output chiplet_pkg::word_t crc
);
    import chiplet_pkg::*;

    localparam word_t POLY = 32'h04C1_1DB7;

    // One word, MSB first, no reflection.
    function automatic word_t crc_fold(input word_t crc_in, input word_t d);
        word_t c;
        logic  fb;
        c = crc_in;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ d[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1; // Preset wins over update.
        end else if (update) begin
            crc <= crc_fold(crc, data);
        end
    end

endmodule

//--- tx_fsm/tx_fsm.sv
`timescale 1ns/1ps
`include "chiplet_config.svh"

module tx_fsm #(
    parameter int NUM_MSGS = `CHIP_NUM_MSGS
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic [NUM_MSGS-1:0]   trigger,
    input  chiplet_pkg::node_id_t node_id,
    input  chiplet_pkg::word_t    head_word,
    input  logic                  not_empty,
    input  logic                  flit_ready,
    output logic                  pop,
    output chiplet_pkg::flit_t    flit,
    output logic                  flit_valid,
    output logic                  busy
);
    import chiplet_pkg::*;

    tx_state_e state, next_state;
    pkt_id_t   pkt_id, next_pkt_id;
    format_e   pkt_fmt, next_pkt_fmt;
    pkt_len_t  pkt_len, next_pkt_len;
    pkt_len_t  word_cnt, next_word_cnt;
    long_hdr_t hdr;
    logic      last_word;
    logic      crc_clear, crc_update;
    word_t     crc_val;

    crc32_gen u_crc (
        .clk    (clk),
        .n_rst  (n_rst),
        .clear  (crc_clear),
        .update (crc_update),
        .data   (head_word),
        .crc    (crc_val)
    );

    assign hdr       = long_hdr_t'(head_word);
    assign last_word = (word_cnt == pkt_len - 1'b1);
    assign busy      = (state != IDLE);

    // ====================
    // State registers
    // ====================

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            pkt_id   <= '0;
            pkt_fmt  <= FMT_LONG_READ;
            pkt_len  <= '0;
            word_cnt <= '0;
        end else begin
            state    <= next_state;
            pkt_id   <= next_pkt_id;
            pkt_fmt  <= next_pkt_fmt;
            pkt_len  <= next_pkt_len;
            word_cnt <= next_word_cnt;
        end
    end

    // ====================
    // Next state and flits
    // ====================

    always_comb begin
        next_state    = state;
        next_pkt_id   = pkt_id;
        next_pkt_fmt  = pkt_fmt;
        next_pkt_len  = pkt_len;
        next_word_cnt = word_cnt;
        pop           = 1'b0;
        flit_valid    = 1'b0;
        crc_clear     = 1'b0;
        crc_update    = 1'b0;

        flit.metadata.vc  = 1'b0;
        flit.metadata.id  = pkt_id;
        flit.metadata.req = node_id;
        flit.payload      = head_word;

        case (state)
            IDLE: begin
                crc_clear     = 1'b1;
                next_word_cnt = '0;
                if (|trigger) begin
                    next_state = START_SEND_PKT;
                    for (int i = 0; i < NUM_MSGS; i++) begin
                        if (trigger[i]) begin
                            next_pkt_id = pkt_id_t'(i); // Highest set bit wins.
                        end
                    end
                end
            end
            START_SEND_PKT: begin
                if (not_empty) begin
                    next_pkt_fmt = hdr.format;
                    next_pkt_len = hdr.length;
                    next_state   = SEND_PKT;
                end
            end
            SEND_PKT: begin
                flit_valid = not_empty;
                if (not_empty && flit_ready) begin
                    pop           = 1'b1;
                    crc_update    = 1'b1;
                    next_word_cnt = word_cnt + 1'b1;
                    if (last_word) begin
                        next_state = (pkt_fmt == FMT_SWITCH_CFG) ? IDLE : CRC;
                    end
                end
            end
            CRC: begin
                flit_valid   = 1'b1;
                flit.payload = crc_val; // Includes the last word.
                if (flit_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!n_rst)
        pop |-> not_empty);

    a_idle_no_flit: assert property (@(posedge clk) disable iff (!n_rst)
        (state == IDLE) |-> !flit_valid);

    a_len_nonzero: assert property (@(posedge clk) disable iff (!n_rst)
        (state == SEND_PKT) |-> (pkt_len != '0));

endmodule

//--- logic/flit_out.sv
`timescale 1ns/1ps

module flit_out (
    input  logic               clk,
    input  logic               n_rst,
    input  chiplet_pkg::flit_t flit,
    input  logic               flit_valid,
    input  logic               out_ack,
    output logic               flit_ready,
    output logic               out_req,
    output chiplet_pkg::flit_t out_flit
);

    typedef enum logic [1:0] {
        OUT_EMPTY,
        OUT_REQ,
        OUT_WAIT_LOW
    } out_state_e;

    out_state_e state;

    assign flit_ready = (state == OUT_EMPTY);
    assign out_req    = (state == OUT_REQ);

    // ====================
    // Four-phase sequencer
    // ====================

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= OUT_EMPTY;
        end else begin
            case (state)
                OUT_EMPTY: begin
                    if (flit_valid) begin
                        state <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (out_ack) begin
                        state <= OUT_WAIT_LOW; // Drop req.
                    end
                end
                OUT_WAIT_LOW: begin
                    if (!out_ack) begin
                        state <= OUT_EMPTY;
                    end
                end
                default: state <= OUT_EMPTY;
            endcase
        end
    end

    // Held until the next capture.
    always_ff @(posedge clk) begin
        if (flit_valid && flit_ready) begin
            out_flit <= flit;
        end
    end

    a_flit_stable: assert property (@(posedge clk) disable iff (!n_rst)
        (out_req && $past(out_req)) |-> $stable(out_flit));

endmodule

//--- logic/chiplet_tx_top.sv
`timescale 1ns/1ps
`include "chiplet_config.svh"

module chiplet_tx_top (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     wr_req,
    input  chiplet_pkg::word_t       wr_data,
    input  logic [`CHIP_NUM_MSGS-1:0] trigger,
    input  chiplet_pkg::node_id_t    node_id,
    input  logic                     out_ack,
    output logic                     wr_ack,
    output logic                     out_req,
    output chiplet_pkg::flit_t       out_flit,
    output logic                     busy
);
    import chiplet_pkg::*;

    word_t head_word;
    logic  not_empty, pop;
    flit_t tx_flit;
    logic  flit_valid, flit_ready;

    msg_fifo #(
        .DEPTH (`CHIP_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .n_rst     (n_rst),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .pop       (pop),
        .wr_ack    (wr_ack),
        .head_word (head_word),
        .not_empty (not_empty)
    );

    tx_fsm #(
        .NUM_MSGS (`CHIP_NUM_MSGS)
    ) u_tx_fsm (
        .clk        (clk),
        .n_rst      (n_rst),
        .trigger    (trigger),
        .node_id    (node_id),
        .head_word  (head_word),
        .not_empty  (not_empty),
        .flit_ready (flit_ready),
        .pop        (pop),
        .flit       (tx_flit),
        .flit_valid (flit_valid),
        .busy       (busy)      // Falls at packet end.
    );

    flit_out u_flit_out (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit       (tx_flit),
        .flit_valid (flit_valid),
        .out_ack    (out_ack),
        .flit_ready (flit_ready),
        .out_req    (out_req),
        .out_flit   (out_flit)
    );

endmodule

//--- dv/tb_chiplet_tx.sv
`timescale 1ns/1ps
`include "chiplet_config.svh"

module tb_chiplet_tx;
    import chiplet_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int TIMEOUT  = 2000; // Cycles per wait.

    logic                      clk;
    logic                      n_rst;
    logic                      wr_req;
    word_t                     wr_data;
    logic [`CHIP_NUM_MSGS-1:0] trigger;
    node_id_t                  node_id;
    logic                      out_ack = 1'b0;
    logic                      wr_ack, out_req, busy;
    flit_t                     out_flit;

    // Packet table, one row per packet.
    format_e                   row_fmt   [NUM_ROWS];
    pkt_len_t                  row_len   [NUM_ROWS];
    logic [`CHIP_NUM_MSGS-1:0] row_trig  [NUM_ROWS];
    pkt_id_t                   row_id    [NUM_ROWS];
    node_id_t                  row_node  [NUM_ROWS];
    bit                        row_first [NUM_ROWS]; // Trigger before the words.
    bit                        row_slow  [NUM_ROWS]; // Long ack delays.

    int    seed      = 93;
    int    ack_delay = 0;
    bit    slow_acks = 1'b0;
    word_t payload_mem [64];
    word_t pkt_words [$];
    flit_t exp_q [$];

    chiplet_tx_top u_dut (
        .clk      (clk),
        .n_rst    (n_rst),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .trigger  (trigger),
        .node_id  (node_id),
        .out_ack  (out_ack),
        .wr_ack   (wr_ack),
        .out_req  (out_req),
        .out_flit (out_flit),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    function automatic word_t crc_ref(input word_t c, input word_t w);
        word_t r;
        r = c;
        for (int b = 31; b >= 0; b--) begin
            if (r[31] != w[b]) begin
                r = (r << 1) ^ 32'h04C1_1DB7;
            end else begin
                r = r << 1;
            end
        end
        return r;
    endfunction

    function automatic flit_t expected_flit(input pkt_id_t id, input node_id_t node,
                                            input word_t w);
        flit_t f;
        f.metadata.vc  = 1'b0;
        f.metadata.id  = id;
        f.metadata.req = node;
        f.payload      = w;
        return f;
    endfunction

    // ====================
    // Checks
    // ====================

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic set_row(input int r, input format_e f, input pkt_len_t len,
                           input logic [`CHIP_NUM_MSGS-1:0] trig, input pkt_id_t id,
                           input node_id_t node, input bit first, input bit slow);
        row_fmt[r]   = f;
        row_len[r]   = len;
        row_trig[r]  = trig;
        row_id[r]    = id;
        row_node[r]  = node;
        row_first[r] = first;
        row_slow[r]  = slow;
    endtask

    // Output sink. Each ack follows a random delay.
    always @(posedge clk) begin
        if (out_ack) begin
            if (!out_req) begin
                out_ack <= 1'b0;
            end
        end else if (out_req) begin
            if (ack_delay > 0) begin
                ack_delay <= ack_delay - 1;
            end else if (exp_q.size() == 0) begin
                $display("unexpected flit %h on the output port at time %0t", out_flit, $time);
                report_failure();
            end else begin
                check_flit("out_flit", out_flit, exp_q.pop_front());
                out_ack   <= 1'b1;
                ack_delay <= ({$random(seed)} % 4) + (slow_acks ? 48 : 0);
            end
        end
    end

    // ====================
    // Host side
    // ====================

    task automatic write_word(input word_t w);
        int cycles;
        @(posedge clk);
        wr_req  <= 1'b1;
        wr_data <= w;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!wr_ack && cycles < TIMEOUT);
        if (!wr_ack) begin
            $display("timeout: wr_ack never rose for word %h", w);
            report_failure();
        end
        wr_req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (wr_ack && cycles < TIMEOUT);
        if (wr_ack) begin
            $display("timeout: wr_ack stayed high after wr_req fell");
            report_failure();
        end
    endtask

    task automatic send_words();
        foreach (pkt_words[k]) begin
            write_word(pkt_words[k]);
        end
    endtask

    task automatic start_packet(input logic [`CHIP_NUM_MSGS-1:0] mask);
        int cycles;
        @(posedge clk);
        trigger <= mask;
        @(posedge clk);
        trigger <= '0; // Seen on this edge.
        cycles = 0;
        while (!busy && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!busy) begin
            $display("timeout: busy never rose after the trigger");
            report_failure();
        end
    endtask

    task automatic finish_packet();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected flits never arrived", exp_q.size());
            report_failure();
        end
        cycles = 0;
        while ((busy || out_req || out_ack) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (busy || out_req || out_ack) begin
            $display("timeout: packet end or final handshake never came");
            report_failure();
        end
        repeat (3) @(posedge clk); // Quiet gap to expose a stray flit.
        check_busy("busy", busy, 1'b0);
        check_busy("out_req", out_req, 1'b0);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int        p_idx;
        word_t     crc;
        long_hdr_t hdr;
        n_rst   = 1'b0;
        wr_req  = 1'b0;
        wr_data = '0;
        trigger = '0;
        node_id = '0;
        for (int i = 0; i < 64; i++) begin
            payload_mem[i] = $random(seed);
        end
        set_row(0, FMT_LONG_WRITE, 8'd5,  4'b0010, 2'd1, 4'd3,  1'b0, 1'b0);
        set_row(1, FMT_SWITCH_CFG, 8'd3,  4'b1000, 2'd3, 4'd5,  1'b0, 1'b0);
        set_row(2, FMT_SHORT,      8'd4,  4'b0101, 2'd2, 4'd9,  1'b0, 1'b0);
        set_row(3, FMT_LONG_READ,  8'd20, 4'b0001, 2'd0, 4'd12, 1'b1, 1'b1);
        set_row(4, FMT_LONG_WRITE, 8'd1,  4'b0100, 2'd2, 4'd6,  1'b0, 1'b1);
        set_row(5, FMT_SHORT,      8'd6,  4'b1100, 2'd3, 4'd10, 1'b0, 1'b1);

        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(posedge clk);
        check_busy("out_req", out_req, 1'b0);
        check_busy("wr_ack", wr_ack, 1'b0);
        check_busy("busy", busy, 1'b0);

        p_idx = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            pkt_words.delete();
            hdr.format   = row_fmt[r];
            hdr.length   = row_len[r];
            hdr.reserved = '0;
            pkt_words.push_back(word_t'(hdr));
            for (int k = 1; k < int'(row_len[r]); k++) begin
                pkt_words.push_back(payload_mem[p_idx]);
                p_idx++;
            end
            crc = '1;
            foreach (pkt_words[k]) begin
                exp_q.push_back(expected_flit(row_id[r], row_node[r], pkt_words[k]));
                crc = crc_ref(crc, pkt_words[k]);
            end
            if (row_fmt[r] != FMT_SWITCH_CFG) begin
                exp_q.push_back(expected_flit(row_id[r], row_node[r], crc));
            end
            slow_acks = row_slow[r];
            @(posedge clk);
            node_id <= row_node[r];
            if (row_first[r]) begin
                start_packet(row_trig[r]);
                send_words();
            end else begin
                send_words();
                start_packet(row_trig[r]);
            end
            finish_packet();
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/chiplet_pkg.sv
logic/msg_fifo.sv
logic/crc32_gen.sv
tx_fsm/tx_fsm.sv
logic/flit_out.sv
logic/chiplet_tx_top.sv
dv/tb_chiplet_tx.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the chiplet transmit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_chiplet_tx -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
